// ==== common/piPkg.sv ====
package piPkg;

  localparam int numLevels = 7;

  // Bit n stands for level n, level 1 is the highest priority
  typedef logic [numLevels:1] levelMask;

  // Zero means no level
  typedef logic [$clog2(numLevels + 1)-1:0] levelNum;

  localparam int cmdWidth = 16;
  typedef logic [cmdWidth-1:0] commandWord;

  // Command word bit positions
  localparam int cmdSysClear = 15;  // Clears on, gen, active and hold
  localparam int cmdOnSet    = 14;
  localparam int cmdOnClr    = 13;
  localparam int cmdGenSet   = 12;  // Software request
  localparam int cmdGenClr   = 11;
  localparam int cmdActOn    = 10;
  localparam int cmdActOff   = 9;

  // Level mask field, bit 0 of the field is level 1
  localparam int cmdMaskLsb  = 0;

  // Status read back, active in the top bit
  typedef struct packed {
    logic     active;
    levelMask onMask;
    levelMask genMask;
    levelMask holdMask;
  } statusWord;

endpackage

// ==== common/busPkg.sv ====
package busPkg;

  localparam int vectorWidth = 18;
  typedef logic [vectorWidth-1:0] vectorWord;

  localparam int funcWidth = 3;
  typedef logic [funcWidth-1:0] funcCode;

  // Bus function codes
  localparam funcCode funcIdle       = 3'b000;
  localparam funcCode funcReadVector = 3'b100;  // Device puts its vector on data

  // Taken when no device answers the vector read in time
  localparam vectorWord defaultVector = 18'o000040;

endpackage

// ==== hw/piCommand.sv ====
module piCommand (
  input  logic              clk,
  input  logic              TIM,
  input  logic              cmdStrobe,
  input  piPkg::commandWord cmdWord,
  output piPkg::levelMask   onMask,
  output piPkg::levelMask   genMask,
  output logic              active,
  output logic              sysClear
);

  logic              strobeDly;
  piPkg::commandWord wordDly;
  piPkg::levelMask   cmdMask;
  piPkg::levelMask   onNext;
  piPkg::levelMask   genNext;
  logic              activeNext;

  // Command is acted on one cycle after the strobe
  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      strobeDly <= 1'b0;
    end else begin
      strobeDly <= cmdStrobe;
    end
  end

  always_ff @(posedge clk) begin
    if (cmdStrobe) begin
      wordDly <= cmdWord;
    end
  end

  assign cmdMask  = wordDly[piPkg::cmdMaskLsb +: piPkg::numLevels];
  assign sysClear = strobeDly & wordDly[piPkg::cmdSysClear];  // Also clears hold

  // Clear wins over set when both are given
  always_comb begin
    onNext     = onMask;
    genNext    = genMask;
    activeNext = active;
    if (strobeDly) begin
      if (wordDly[piPkg::cmdOnSet])  onNext = onNext | cmdMask;
      if (wordDly[piPkg::cmdOnClr])  onNext = onNext & ~cmdMask;
      if (wordDly[piPkg::cmdGenSet]) genNext = genNext | cmdMask;
      if (wordDly[piPkg::cmdGenClr]) genNext = genNext & ~cmdMask;
      if (wordDly[piPkg::cmdActOn])  activeNext = 1'b1;
      if (wordDly[piPkg::cmdActOff]) activeNext = 1'b0;
    end
  end

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      onMask  <= '0;
      genMask <= '0;
      active  <= 1'b0;
    end else if (sysClear) begin
      onMask  <= '0;
      genMask <= '0;
      active  <= 1'b0;
    end else begin
      onMask  <= onNext;
      genMask <= genNext;
      active  <= activeNext;
    end
  end

endmodule

// ==== hw/piArbiter/piPriority.sv ====
module piPriority (
  input  logic            clk,
  input  logic            TIM,
  input  piPkg::levelMask ioReq,
  input  piPkg::levelMask onMask,
  input  piPkg::levelMask genMask,
  input  logic            active,
  input  logic            sysClear,
  input  logic            setHold,
  input  piPkg::levelNum  holdLevel,
  input  logic            dismiss,
  output piPkg::levelNum  reqLevel,
  output piPkg::levelMask holdMask
);

  piPkg::levelMask reqMask;
  piPkg::levelMask eligMask;
  piPkg::levelMask setVec;
  piPkg::levelMask clrVec;
  piPkg::levelNum  topHold;

  // Lowest-numbered set bit, zero when the mask is empty
  function automatic piPkg::levelNum firstLevel(piPkg::levelMask m);
    piPkg::levelNum lvl;
    lvl = '0;
    for (int n = piPkg::numLevels; n >= 1; n--) begin
      if (m[n]) lvl = piPkg::levelNum'(n);
    end
    return lvl;
  endfunction

  // Gen alone requests, a device request needs its level on
  assign reqMask = active ? (genMask | (onMask & ioReq)) : '0;

  assign topHold = firstLevel(holdMask);  // Level currently being serviced

  always_comb begin
    for (int n = 1; n <= piPkg::numLevels; n++) begin
      // Only levels above the highest held one may interrupt
      eligMask[n] = (topHold == '0) || (n < int'(topHold));
      setVec[n]   = setHold && (holdLevel == piPkg::levelNum'(n));
      clrVec[n]   = dismiss && (topHold == piPkg::levelNum'(n));
    end
  end

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      holdMask <= '0;
    end else if (sysClear) begin
      holdMask <= '0;
    end else begin
      holdMask <= (holdMask | setVec) & ~clrVec;
    end
  end

  assign reqLevel = firstLevel(reqMask & eligMask);

endmodule

// ==== hw/piArbiter/piSequencer.sv ====
module piSequencer (
  input  logic              clk,
  input  logic              TIM,
  input  piPkg::levelNum    reqLevel,
  input  logic              takeInt,
  input  logic              busXfer,
  input  busPkg::vectorWord busData,
  input  logic              timedOut,
  output logic              intReq,
  output piPkg::levelNum    intLevel,
  output logic              setHold,
  output piPkg::levelNum    holdLevel,
  output logic              busDemand,
  output busPkg::funcCode   busFunc,
  output logic              timerRun,
  output logic              vectorValid,
  output busPkg::vectorWord vector,
  output logic              vectorTimeout
);

  typedef enum logic [1:0] {
    idleSt,
    offerSt,
    readSt,
    doneSt
  } seqState;

  seqState state;
  seqState stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      idleSt:  if (reqLevel != '0) stateNext = offerSt;
      offerSt: if (takeInt) stateNext = readSt;  // Waits here until taken
      readSt:  if (busXfer || timedOut) stateNext = doneSt;
      default: stateNext = idleSt;
    endcase
  end

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      state    <= idleSt;
      intLevel <= '0;
    end else begin
      state <= stateNext;
      if (state == idleSt) intLevel <= reqLevel;  // Frozen once offered
    end
  end

  // Device answer has priority over a timeout on the same edge
  always_ff @(posedge clk) begin
    if (state == readSt) begin
      if (busXfer) begin
        vector        <= busData;
        vectorTimeout <= 1'b0;
      end else if (timedOut) begin
        vector        <= busPkg::defaultVector;
        vectorTimeout <= 1'b1;
      end
    end
  end

  assign intReq      = (state == offerSt);
  assign setHold     = intReq & takeInt;
  assign holdLevel   = intLevel;
  assign busDemand   = (state == readSt);
  assign busFunc     = busDemand ? busPkg::funcReadVector : busPkg::funcIdle;
  assign timerRun    = busDemand;
  assign vectorValid = (state == doneSt);  // One cycle, then back to idle

endmodule

// ==== hw/piArbiter/cycleTimer.sv ====
module cycleTimer #(
  parameter int timeoutCycles = 15
) (
  input  logic clk,
  input  logic TIM,
  input  logic timerRun,
  output logic timedOut
);

  localparam int cntWidth = $clog2(timeoutCycles + 1);

  logic [cntWidth-1:0] count;

  // Counts bus wait cycles, holds at the limit
  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      count <= '0;
    end else if (!timerRun) begin
      count <= '0;
    end else if (!timedOut) begin
      count <= count + 1'b1;
    end
  end

  assign timedOut = (count == cntWidth'(timeoutCycles));

endmodule

// ==== hw/piTop.sv ====
module piTop #(
  parameter int timeoutCycles = 15
) (
  input  logic              clk,
  input  logic              TIM,
  input  logic              cmdStrobe,
  input  piPkg::commandWord cmdWord,
  input  piPkg::levelMask   ioReq,
  input  logic              takeInt,
  input  logic              dismiss,
  input  logic              busXfer,
  input  busPkg::vectorWord busData,
  output logic              intReq,
  output piPkg::levelNum    intLevel,
  output logic              busDemand,
  output busPkg::funcCode   busFunc,
  output logic              vectorValid,
  output busPkg::vectorWord vector,
  output logic              vectorTimeout,
  output piPkg::statusWord  status
);

  piPkg::levelMask onMask;
  piPkg::levelMask genMask;
  piPkg::levelMask holdMask;
  logic            active;
  logic            sysClear;
  piPkg::levelNum  reqLevel;
  logic            setHold;
  piPkg::levelNum  holdLevel;
  logic            timerRun;
  logic            timedOut;

  piCommand command0 (
    .clk      (clk),
    .TIM      (TIM),
    .cmdStrobe(cmdStrobe),
    .cmdWord  (cmdWord),
    .onMask   (onMask),
    .genMask  (genMask),
    .active   (active),
    .sysClear (sysClear)
  );

  piPriority priority0 (
    .clk      (clk),
    .TIM      (TIM),
    .ioReq    (ioReq),
    .onMask   (onMask),
    .genMask  (genMask),
    .active   (active),
    .sysClear (sysClear),
    .setHold  (setHold),
    .holdLevel(holdLevel),
    .dismiss  (dismiss),
    .reqLevel (reqLevel),
    .holdMask (holdMask)
  );

  piSequencer sequencer0 (
    .clk          (clk),
    .TIM          (TIM),
    .reqLevel     (reqLevel),
    .takeInt      (takeInt),
    .busXfer      (busXfer),
    .busData      (busData),
    .timedOut     (timedOut),
    .intReq       (intReq),
    .intLevel     (intLevel),
    .setHold      (setHold),
    .holdLevel    (holdLevel),
    .busDemand    (busDemand),
    .busFunc      (busFunc),
    .timerRun     (timerRun),
    .vectorValid  (vectorValid),
    .vector       (vector),
    .vectorTimeout(vectorTimeout)
  );

  cycleTimer #(
    .timeoutCycles(timeoutCycles)
  ) timer0 (
    .clk     (clk),
    .TIM     (TIM),
    .timerRun(timerRun),
    .timedOut(timedOut)
  );

  // Status word gathered from the level registers
  assign status = '{active: active, onMask: onMask, genMask: genMask, holdMask: holdMask};

endmodule

// ==== bench/clockGen.sv ====
module clockGen #(
  parameter int period      = 10,
  parameter int resetCycles = 3
) (
  output logic clk,
  output logic TIM
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    TIM = 1'b1;
    repeat (resetCycles) @(posedge clk);
    TIM <= 1'b0;
  end

endmodule

// ==== bench/piTop_asserts.sv ====
module piTop_asserts (
  input logic           clk,
  input logic           TIM,
  input logic           intReq,
  input piPkg::levelNum intLevel,
  input logic           busDemand,
  input logic           vectorValid
);

  // Offered level must not move until the processor takes it
  property levelFrozen;
    @(posedge clk) disable iff (TIM)
      intReq |=> (!intReq || $stable(intLevel));
  endproperty

  property validOneCycle;
    @(posedge clk) disable iff (TIM)
      vectorValid |=> !vectorValid;
  endproperty

  property offerOrRead;
    @(posedge clk) disable iff (TIM)
      !(busDemand && intReq);  // Offer and vector read never overlap
  endproperty

  levelFrozenChk: assert property (levelFrozen)
    else $error("intLevel changed while intReq was high");

  validOneCycleChk: assert property (validOneCycle)
    else $error("vectorValid stayed high for more than one cycle");

  offerOrReadChk: assert property (offerOrRead)
    else $error("busDemand and intReq high together");

endmodule

bind piTop piTop_asserts checks0 (
  .clk        (clk),
  .TIM        (TIM),
  .intReq     (intReq),
  .intLevel   (intLevel),
  .busDemand  (busDemand),
  .vectorValid(vectorValid)
);

// ==== bench/piTb.sv ====
module piTb;

  localparam int timeoutCycles = 15;
  localparam int numRows       = 14;
  localparam int quietCycles   = 8;  // Window in which no request may show
  localparam int cycleLimit    = numRows * (timeoutCycles + 20);

  typedef struct packed {
    piPkg::commandWord cmd;
    piPkg::levelMask   req;
    logic              dis;
    logic              take;
    logic signed [7:0] xferDelay;  // Negative means the device never answers
    piPkg::levelNum    expLevel;
    logic              expTimeout;
    busPkg::vectorWord data;
    piPkg::statusWord  expStatus;
  } rowEntry;

  logic              clk;
  logic              TIM;
  logic              cmdStrobe;
  piPkg::commandWord cmdWord;
  piPkg::levelMask   ioReq;
  logic              takeInt;
  logic              dismiss;
  logic              busXfer;
  busPkg::vectorWord busData;
  logic              intReq;
  piPkg::levelNum    intLevel;
  logic              busDemand;
  busPkg::funcCode   busFunc;
  logic              vectorValid;
  busPkg::vectorWord vector;
  logic              vectorTimeout;
  piPkg::statusWord  status;

  rowEntry     rows [numRows];
  int          errorCount;
  int          rowErrors;
  int          failedRows;
  int          cycleCount;

  clockGen #(
    .period     (10),
    .resetCycles(3)
  ) clocks0 (
    .clk(clk),
    .TIM(TIM)
  );

  piTop #(
    .timeoutCycles(timeoutCycles)
  ) dut0 (
    .clk          (clk),
    .TIM          (TIM),
    .cmdStrobe    (cmdStrobe),
    .cmdWord      (cmdWord),
    .ioReq        (ioReq),
    .takeInt      (takeInt),
    .dismiss      (dismiss),
    .busXfer      (busXfer),
    .busData      (busData),
    .intReq       (intReq),
    .intLevel     (intLevel),
    .busDemand    (busDemand),
    .busFunc      (busFunc),
    .vectorValid  (vectorValid),
    .vector       (vector),
    .vectorTimeout(vectorTimeout),
    .status       (status)
  );

  // One function bit plus the level mask field
  function automatic piPkg::commandWord commandFor(int bitPos, logic [6:0] mask);
    piPkg::commandWord w;
    w         = '0;
    w[bitPos] = 1'b1;
    w[6:0]    = mask;
    return w;
  endfunction

  function automatic logic [21:0] statusOf(logic act, logic [6:0] on, logic [6:0] gen,
                                           logic [6:0] hold);
    return {act, on, gen, hold};
  endfunction

  function automatic rowEntry makeRow(piPkg::commandWord cmd, logic [6:0] req, logic dis,
                                      logic take, int delay, int lvl, logic toExp,
                                      logic [21:0] stat);
    rowEntry r;
    r.cmd        = cmd;
    r.req        = req;
    r.dis        = dis;
    r.take       = take;
    r.xferDelay  = 8'(delay);
    r.expLevel   = piPkg::levelNum'(lvl);
    r.expTimeout = toExp;
    r.data       = '0;
    r.expStatus  = stat;
    return r;
  endfunction

  task automatic fillTable();
    // Levels 1, 3 and 5 turned on while the system is still inactive
    rows[0]  = makeRow(commandFor(piPkg::cmdOnSet, 7'b0010101), 7'b0000100, 0, 0, -1, 0, 0,
                       statusOf(0, 7'b0010101, 7'b0000000, 7'b0000000));
    rows[1]  = makeRow(commandFor(piPkg::cmdActOn, 7'b0), 7'b0001010, 0, 0, -1, 0, 0,
                       statusOf(1, 7'b0010101, 7'b0000000, 7'b0000000));
    rows[2]  = makeRow(commandFor(piPkg::cmdGenSet, 7'b0100000), 7'b0, 0, 1, 2, 6, 0,
                       statusOf(1, 7'b0010101, 7'b0100000, 7'b0100000));
    rows[3]  = makeRow(commandFor(piPkg::cmdGenClr, 7'b0100000), 7'b0, 1, 0, -1, 0, 0,
                       statusOf(1, 7'b0010101, 7'b0000000, 7'b0000000));
    rows[4]  = makeRow('0, 7'b0010100, 0, 1, 0, 3, 0,
                       statusOf(1, 7'b0010101, 7'b0000000, 7'b0000100));
    rows[5]  = makeRow(commandFor(piPkg::cmdGenSet, 7'b0001000), 7'b0010100, 0, 0, -1, 0, 0,
                       statusOf(1, 7'b0010101, 7'b0001000, 7'b0000100));
    rows[6]  = makeRow('0, 7'b0010101, 0, 1, -1, 1, 1,
                       statusOf(1, 7'b0010101, 7'b0001000, 7'b0000101));
    rows[7]  = makeRow('0, 7'b0010000, 1, 0, -1, 0, 0,
                       statusOf(1, 7'b0010101, 7'b0001000, 7'b0000100));
    rows[8]  = makeRow('0, 7'b0010000, 1, 1, 3, 4, 0,
                       statusOf(1, 7'b0010101, 7'b0001000, 7'b0001000));
    rows[9]  = makeRow(commandFor(piPkg::cmdGenClr, 7'b0001000), 7'b0010000, 1, 1, 1, 5, 0,
                       statusOf(1, 7'b0010101, 7'b0000000, 7'b0010000));
    rows[10] = makeRow(commandFor(piPkg::cmdOnClr, 7'b0010000), 7'b0, 1, 0, -1, 0, 0,
                       statusOf(1, 7'b0000101, 7'b0000000, 7'b0000000));
    rows[11] = makeRow(commandFor(piPkg::cmdGenSet, 7'b0000010), 7'b0, 0, 1, 4, 2, 0,
                       statusOf(1, 7'b0000101, 7'b0000010, 7'b0000010));
    rows[12] = makeRow(commandFor(piPkg::cmdSysClear, 7'b0), 7'b0, 0, 0, -1, 0, 0,
                       statusOf(0, 7'b0000000, 7'b0000000, 7'b0000000));
    rows[13] = makeRow(commandFor(piPkg::cmdActOn, 7'b0) | commandFor(piPkg::cmdOnSet, 7'b1000000),
                       7'b1000000, 0, 1, -1, 7, 1,
                       statusOf(1, 7'b1000000, 7'b0000000, 7'b1000000));
    for (int i = 0; i < numRows; i++) begin
      rows[i].data = busPkg::vectorWord'($urandom);
    end
  endtask

  task automatic compareValue(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, expected);
      errorCount++;
      rowErrors++;
    end
  endtask

  task automatic expectQuiet();
    for (int i = 0; i < quietCycles; i++) begin
      @(negedge clk);
      if (intReq) begin
        compareValue("intReq", 32'(intReq), 32'd0);
        break;
      end
    end
  endtask

  // Take the offered level, then answer or withhold the vector read
  task automatic serviceRequest(rowEntry r);
    @(negedge clk);
    while (!intReq) @(negedge clk);
    compareValue("intLevel", 32'(intLevel), 32'(r.expLevel));
    @(posedge clk);
    takeInt <= 1'b1;
    @(posedge clk);
    takeInt <= 1'b0;
    @(negedge clk);
    while (!busDemand) @(negedge clk);
    compareValue("busFunc", 32'(busFunc), 32'(busPkg::funcReadVector));
    compareValue("intReq", 32'(intReq), 32'd0);
    if (r.xferDelay >= 0) begin
      repeat (r.xferDelay) @(posedge clk);
      @(posedge clk);
      busXfer <= 1'b1;
      busData <= r.data;
      @(posedge clk);
      busXfer <= 1'b0;
    end
    @(negedge clk);
    while (!vectorValid) @(negedge clk);
    if (r.expTimeout) begin
      compareValue("vector", 32'(vector), 32'(busPkg::defaultVector));
      compareValue("vectorTimeout", 32'(vectorTimeout), 32'd1);
    end else begin
      compareValue("vector", 32'(vector), 32'(r.data));
      compareValue("vectorTimeout", 32'(vectorTimeout), 32'd0);
    end
  endtask

  task automatic applyRow(int idx);
    rowEntry r;
    r         = rows[idx];
    rowErrors = 0;
    @(posedge clk);
    ioReq     <= r.req;
    cmdStrobe <= (r.cmd != '0);
    cmdWord   <= r.cmd;
    @(posedge clk);
    cmdStrobe <= 1'b0;
    @(posedge clk);
    dismiss <= r.dis;  // Command has landed by now
    @(posedge clk);
    dismiss <= 1'b0;
    if (r.take) begin
      serviceRequest(r);
    end else begin
      expectQuiet();
    end
    @(negedge clk);
    compareValue("status", 32'(status), 32'(r.expStatus));
    if (rowErrors != 0) begin
      failedRows++;
      $display("row %0d: %0d mismatches", idx, rowErrors);
    end else begin
      $display("row %0d: ok", idx);
    end
  endtask

  initial begin
    cmdStrobe  = 1'b0;
    cmdWord    = '0;
    ioReq      = '0;
    takeInt    = 1'b0;
    dismiss    = 1'b0;
    busXfer    = 1'b0;
    busData    = busPkg::vectorWord'($urandom(32'heb703656));  // Seeds the generator
    errorCount = 0;
    rowErrors  = 0;
    failedRows = 0;
    fillTable();
    @(negedge TIM);
    for (int i = 0; i < numRows; i++) begin
      applyRow(i);
    end
    $display("rows run %0d, passed %0d, failed %0d", numRows, numRows - failedRows,
             failedRows);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog sized from the row count
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Run stopped because the rows did not finish within %0d cycles", cycleLimit);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== piSys.f ====
common/piPkg.sv
common/busPkg.sv
hw/piCommand.sv
hw/piArbiter/piPriority.sv
hw/piArbiter/piSequencer.sv
hw/piArbiter/cycleTimer.sv
hw/piTop.sv
bench/clockGen.sv
bench/piTop_asserts.sv
bench/piTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module piTb -f piSys.f -o piSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/piSim 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
